/* verilog/int_pipe_params.svh */
// width and size macros for the integer pipeline, included by the package and every RTL file
`ifndef INT_PIPE_PARAMS_SVH
`define INT_PIPE_PARAMS_SVH

// --------------------------------------------------
// datapath and instruction widths
// --------------------------------------------------
`define XLEN 32
`define INSTR_W 32

// --------------------------------------------------
// register file geometry
// --------------------------------------------------
`define REG_COUNT 32
`define REG_ADDR_W 5
`define SHAMT_W 5

`endif

/* verilog/int_pipe_pkg.sv */
// shared opcode and ALU enums plus the pipeline record structs used across the core
`include "int_pipe_params.svh"

package int_pipe_pkg;

	// major opcodes the core executes
	typedef enum logic [6:0] {
		op_reg = 7'b0110011,
		op_imm = 7'b0010011
	} opcode_e;

	// alu operations, shared by R-type and I-type forms
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_op_e;

	// one decoded instruction
	typedef struct packed {
		logic                   legal;
		alu_op_e                alu_op;
		logic                   use_imm;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`XLEN-1:0]       imm;
	} decode_t;

	// contents of the issue register
	typedef struct packed {
		decode_t          dec;
		logic [`XLEN-1:0] rs1_data;
		logic [`XLEN-1:0] rs2_data;
	} issue_t;

	// writeback record, also the register file write port
	typedef struct packed {
		logic                   valid;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       data;
	} wb_t;

endpackage

/* verilog/decode_unit.sv */
// combinational RV32I decoder for the ALU subset, producing control fields and the immediate
`timescale 1ns/1ps
`include "int_pipe_params.svh"

module decode_unit (
	input  logic [`INSTR_W-1:0]  instr,
	output int_pipe_pkg::decode_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       is_reg;
	logic       is_imm;
	logic       is_shift;
	logic       funct7_ok;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign is_reg   = (opcode == int_pipe_pkg::op_reg);
	assign is_imm   = (opcode == int_pipe_pkg::op_imm);
	assign is_shift = (funct3[1:0] == 2'b01);

	// funct7 is zero, or the alternate form on sub and sra/srai
	assign funct7_ok = (funct7 == 7'b0000000) ||
		((funct7 == 7'b0100000) && ((funct3 == 3'b101) || (is_reg && funct3 == 3'b000)));

	// --------------------------------------------------
	// control fields
	// --------------------------------------------------
	always_comb begin
		dec = '0;
		dec.rd      = instr[11:7];
		dec.rs1     = instr[19:15];
		dec.rs2     = instr[24:20];
		dec.use_imm = is_imm;

		// immediate forms only constrain funct7 on shifts
		dec.legal = (is_reg && funct7_ok) || (is_imm && (!is_shift || funct7_ok));

		case (funct3)
			3'b000: begin
				if (is_reg && instr[30]) begin
					dec.alu_op = int_pipe_pkg::alu_sub;
				end else begin
					dec.alu_op = int_pipe_pkg::alu_add;
				end
			end
			3'b001: dec.alu_op = int_pipe_pkg::alu_sll;
			3'b010: dec.alu_op = int_pipe_pkg::alu_slt;
			3'b011: dec.alu_op = int_pipe_pkg::alu_sltu;
			3'b100: dec.alu_op = int_pipe_pkg::alu_xor;
			3'b101: begin
				if (instr[30]) begin
					dec.alu_op = int_pipe_pkg::alu_sra;
				end else begin
					dec.alu_op = int_pipe_pkg::alu_srl;
				end
			end
			3'b110: dec.alu_op = int_pipe_pkg::alu_or;
			default: dec.alu_op = int_pipe_pkg::alu_and;
		endcase

		// shift-immediates carry only the shift amount
		if (is_shift) begin
			dec.imm = {{(`XLEN-`SHAMT_W){1'b0}}, instr[20 +: `SHAMT_W]};
		end else begin
			dec.imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
		end
	end

endmodule

/* verilog/reg_file.sv */
// 32-entry integer register file with hardwired x0 and write-through on both read ports
`timescale 1ns/1ps
`include "int_pipe_params.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] rs1,
	input  logic [`REG_ADDR_W-1:0] rs2,
	input  int_pipe_pkg::wb_t      wb,
	output logic [`XLEN-1:0]       rs1_data,
	output logic [`XLEN-1:0]       rs2_data
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:`REG_COUNT-1];
	logic             wr_en;

	assign wr_en = wb.valid && (wb.rd != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// one read port, bypassing the write in flight
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] idx);
		if (idx == '0) begin
			return '0;
		end else if (wr_en && (idx == wb.rd)) begin
			return wb.data;
		end else begin
			return regs[idx];
		end
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

endmodule

/* verilog/execute_stage.sv */
// issue register, operand forwarding, ALU and writeback register of the integer pipeline
`timescale 1ns/1ps
`include "int_pipe_params.svh"

module execute_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid,
	input  int_pipe_pkg::decode_t dec,
	input  logic [`XLEN-1:0]      rs1_data,
	input  logic [`XLEN-1:0]      rs2_data,
	output int_pipe_pkg::wb_t     wb
);

	int_pipe_pkg::issue_t     iss;
	logic                     fwd_rs1;
	logic                     fwd_rs2;
	logic [`XLEN-1:0]         src1;
	logic [`XLEN-1:0]         rs2_val;
	logic [`XLEN-1:0]         src2;
	logic [`SHAMT_W-1:0]      shamt;
	logic [`XLEN-1:0]         result;

	// --------------------------------------------------
	// issue register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			iss.dec.legal <= 1'b0;
		end else begin
			iss.dec       <= dec;
			iss.rs1_data  <= rs1_data;
			iss.rs2_data  <= rs2_data;
			// not valid or not legal, becomes a bubble
			iss.dec.legal <= instr_valid && dec.legal;
		end
	end

	// --------------------------------------------------
	// forwarding from the writeback register
	// --------------------------------------------------
	// wb always holds the instruction just ahead of iss
	assign fwd_rs1 = wb.valid && (wb.rd != '0) && (wb.rd == iss.dec.rs1);
	assign fwd_rs2 = wb.valid && (wb.rd != '0) && (wb.rd == iss.dec.rs2);

	assign src1    = fwd_rs1 ? wb.data : iss.rs1_data;
	assign rs2_val = fwd_rs2 ? wb.data : iss.rs2_data;
	assign src2    = iss.dec.use_imm ? iss.dec.imm : rs2_val;
	assign shamt   = src2[`SHAMT_W-1:0];

	// --------------------------------------------------
	// alu
	// --------------------------------------------------
	always_comb begin
		case (iss.dec.alu_op)
			int_pipe_pkg::alu_add:  result = src1 + src2;
			int_pipe_pkg::alu_sub:  result = src1 - src2;
			int_pipe_pkg::alu_sll:  result = src1 << shamt;
			int_pipe_pkg::alu_slt:  result = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
			int_pipe_pkg::alu_sltu: result = {{(`XLEN-1){1'b0}}, src1 < src2};
			int_pipe_pkg::alu_xor:  result = src1 ^ src2;
			int_pipe_pkg::alu_srl:  result = src1 >> shamt;
			// arithmetic shift keeps the sign bit
			int_pipe_pkg::alu_sra:  result = $unsigned($signed(src1) >>> shamt);
			int_pipe_pkg::alu_or:   result = src1 | src2;
			int_pipe_pkg::alu_and:  result = src1 & src2;
			default:                result = '0;
		endcase
	end

	// --------------------------------------------------
	// writeback register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= iss.dec.legal;
			wb.rd    <= iss.dec.rd;
			wb.data  <= result;
		end
	end

endmodule

/* verilog/int_pipe.sv */
// top level of the integer pipeline, one instruction in per strobe and one result strobe out
`timescale 1ns/1ps
`include "int_pipe_params.svh"

module int_pipe (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  logic [`INSTR_W-1:0]    instr,
	output logic                   wb_valid,
	output logic [`REG_ADDR_W-1:0] wb_rd,
	output logic [`XLEN-1:0]       wb_data
);

	int_pipe_pkg::decode_t dec;
	int_pipe_pkg::wb_t     wb;
	logic [`XLEN-1:0]      rs1_data;
	logic [`XLEN-1:0]      rs2_data;

	// decode and register read side by side
	decode_unit decode_unit_i (
		.instr (instr),
		.dec   (dec)
	);

	reg_file reg_file_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (instr[19:15]),
		.rs2      (instr[24:20]),
		.wb       (wb),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	execute_stage execute_stage_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.dec         (dec),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.wb          (wb)
	);

	// result port
	assign wb_valid = wb.valid;
	assign wb_rd    = wb.rd;
	assign wb_data  = wb.data;

endmodule

/* tb/int_pipe_chk.sv */
// concurrent checks on the int_pipe result port, attached to every int_pipe instance by bind
`timescale 1ns/1ps
`include "int_pipe_params.svh"

module int_pipe_chk (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   instr_valid,
	input logic                   wb_valid,
	input logic [`REG_ADDR_W-1:0] wb_rd
);

	// high once an edge has seen reset
	logic rst_seen_q;

	always @(posedge clk) begin
		rst_seen_q <= !rst_n;
	end

	reset_quiet: assert property (@(posedge clk) (rst_seen_q && !rst_n) |-> !wb_valid)
		else $error("wb_valid high while rst_n is low");

	// two edges from presentation to result
	result_has_source: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> $past(instr_valid, 2))
		else $error("wb_valid without an instruction two edges earlier");

	rd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (!$isunknown(wb_rd) && int'(wb_rd) < `REG_COUNT))
		else $error("wb_rd unknown or out of range");

endmodule

bind int_pipe int_pipe_chk int_pipe_chk_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.wb_valid    (wb_valid),
	.wb_rd       (wb_rd)
);

/* tb/int_pipe_tb.sv */
// directed testbench for int_pipe, run as the simulation top and checked against a register model
`timescale 1ns/1ps
`include "int_pipe_params.svh"

module int_pipe_tb;

	localparam int TEST_CYCLES = 700;
	localparam int MAX_CYCLES  = 4 * TEST_CYCLES + 200;
	// funct3 of the ten R-type operations, add first
	localparam logic [29:0] F3_TABLE = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   instr_valid;
	logic [`INSTR_W-1:0]    instr;
	logic                   wb_valid;
	logic [`REG_ADDR_W-1:0] wb_rd;
	logic [`XLEN-1:0]       wb_data;
	int                     errors;
	int                     cycles = 0;
	int                     seed;
	logic [`XLEN-1:0]       model_regs [`REG_COUNT];
	logic [`REG_ADDR_W-1:0] exp_rd_q [$];
	logic [`XLEN-1:0]       exp_data_q [$];

	int_pipe int_pipe_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [4:0] rand_reg();
		logic [31:0] v;
		v = $random(seed);
		return 5'(v[15:0] % 16'd31) + 5'd1;
	endfunction

	// op 0..9 is add, sub, sll, slt, sltu, xor, srl, sra, or, and
	function automatic logic [31:0] r_word(input int op, input logic [4:0] rd, rs1, rs2);
		logic [6:0] f7;
		f7 = (op == 1 || op == 7) ? 7'h20 : 7'h00;
		return {f7, rs2, rs1, F3_TABLE[op*3 +: 3], rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd, rs1,
		input logic [11:0] imm);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	// --------------------------------------------------
	// reference model, one instruction per call in issue order
	// --------------------------------------------------
	task automatic model_step(input logic [31:0] word);
		logic [2:0]         f3;
		logic [6:0]         f7;
		logic [4:0]         rd;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic [31:0]        res;
		logic               alt;
		logic               legal;
		f3 = word[14:12];
		f7 = word[31:25];
		rd = word[11:7];
		sa = model_regs[word[19:15]];
		sb = model_regs[word[24:20]];
		alt = 1'b0;
		legal = 1'b0;
		if (word[6:0] == 7'b0110011) begin
			legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			alt = word[30];
		end else if (word[6:0] == 7'b0010011) begin
			legal = (f3 == 3'd1) ? (f7 == 7'h00) :
				(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
			alt = (f3 == 3'd5) && word[30];
			sb = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, word[24:20]} : {{20{word[31]}}, word[31:20]};
		end
		if (legal) begin
			case (f3)
				3'd0: res = alt ? sa - sb : sa + sb;
				3'd1: res = sa << sb[4:0];
				3'd2: res = (sa < sb) ? 32'd1 : 32'd0;
				3'd3: res = ($unsigned(sa) < $unsigned(sb)) ? 32'd1 : 32'd0;
				3'd4: res = sa ^ sb;
				// arithmetic shift kept signed on its own
				3'd5: res = alt ? $unsigned(sa >>> sb[4:0]) : $unsigned(sa) >> sb[4:0];
				3'd6: res = sa | sb;
				default: res = sa & sb;
			endcase
			if (rd != 5'd0) begin
				model_regs[rd] = res;
			end
			exp_rd_q.push_back(rd);
			exp_data_q.push_back(res);
		end
	endtask

	task automatic send(input logic [31:0] word);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= word;
		model_step(word);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instr <= '0;
		end
	endtask

	task automatic wait_results();
		while (exp_rd_q.size() != 0) begin
			idle(1);
		end
		idle(2);
	endtask

	task automatic read_all_regs();
		for (int r = 0; r < `REG_COUNT; r++) begin
			send(r_word(0, 5'(r), 5'(r), 5'd0));
		end
		wait_results();
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_reset();
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			if (i == 15) begin
				rst_n <= 1'b1;
			end
			@(negedge clk);
			check_value("wb_valid", 32'(wb_valid), 32'd0);
		end
		idle(6);
		read_all_regs();
	endtask

	task automatic test_reg_ops();
		logic [31:0] v;
		for (int r = 1; r < `REG_COUNT; r++) begin
			v = $random(seed);
			send(i_word(3'd0, 5'(r), 5'd0, v[11:0]));
			send(i_word(3'd1, 5'(r), 5'(r), {7'd0, v[16:12]}));
			send(i_word(3'd4, 5'(r), 5'(r), v[31:20]));
		end
		// negative against positive, signed and unsigned
		send(i_word(3'd0, 5'd1, 5'd0, 12'hffb));
		send(i_word(3'd0, 5'd2, 5'd0, 12'h007));
		send(r_word(3, 5'd3, 5'd1, 5'd2));
		send(r_word(4, 5'd4, 5'd1, 5'd2));
		for (int k = 0; k < 40; k++) begin
			send(r_word(k % 10, rand_reg(), rand_reg(), rand_reg()));
		end
		wait_results();
	endtask

	task automatic test_imm_ops();
		logic [31:0] v;
		send(i_word(3'd0, 5'd5, 5'd0, 12'h9c3));
		for (int f = 0; f < 8; f++) begin
			v = $random(seed);
			if (f == 1) begin
				send(i_word(3'd1, 5'd6, 5'd5, {7'h00, v[4:0]}));
			end else if (f == 5) begin
				send(i_word(3'd5, 5'd7, 5'd5, {7'h00, v[4:0]}));
				send(i_word(3'd5, 5'd8, 5'd5, {7'h20, v[9:5]}));
			end else begin
				send(i_word(3'(f), 5'd9, rand_reg(), {1'b1, v[10:0]}));
				send(i_word(3'(f), 5'd10, 5'd5, {1'b0, v[22:12]}));
			end
		end
		wait_results();
	endtask

	task automatic test_forwarding();
		logic [31:0] v;
		logic [4:0]  last;
		logic [4:0]  prev;
		logic [4:0]  rd;
		for (int gap = 0; gap < 3; gap++) begin
			v = $random(seed);
			send(i_word(3'd0, 5'd20, 5'd0, v[11:0]));
			send(i_word(3'd4, 5'd21, 5'd20, v[23:12]));
			prev = 5'd20;
			last = 5'd21;
			for (int k = 0; k < 10; k++) begin
				idle(gap);
				v = $random(seed);
				rd = rand_reg();
				if (k % 2 == 0) begin
					send(r_word(int'(v[7:0]) % 10, rd, last, prev));
				end else begin
					send(i_word((k % 4 == 1) ? 3'd0 : 3'd4, rd, last, v[31:20]));
				end
				prev = last;
				last = rd;
			end
			wait_results();
		end
	endtask

	task automatic test_zero_and_bubbles();
		send(i_word(3'd0, 5'd0, 5'd0, 12'd123));
		send(r_word(0, 5'd1, 5'd0, 5'd0));
		send(r_word(0, 5'd0, 5'd3, 5'd4));
		send(r_word(0, 5'd2, 5'd0, 5'd3));
		wait_results();
		// load, store, lui, mul and slli with a bad funct7
		send({12'h005, 5'd1, 3'd2, 5'd7, 7'b0000011});
		send({7'h00, 5'd7, 5'd1, 3'd2, 5'd5, 7'b0100011});
		send({20'h12345, 5'd8, 7'b0110111});
		send({7'h01, 5'd2, 5'd3, 3'd0, 5'd9, 7'b0110011});
		send({7'h20, 5'd3, 5'd4, 3'd1, 5'd10, 7'b0010011});
		idle(6);
		read_all_regs();
	endtask

	// --------------------------------------------------
	// result monitor and run control
	// --------------------------------------------------
	always @(negedge clk) begin
		if (rst_n === 1'b1 && wb_valid !== 1'b0) begin
			if (exp_rd_q.size() == 0) begin
				errors++;
				$display("unexpected result strobe at %0d ns with nothing outstanding", $time);
			end else begin
				check_value("wb_rd", 32'(wb_rd), 32'(exp_rd_q.pop_front()));
				check_value("wb_data", wb_data, exp_data_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles with %0d results outstanding", cycles, exp_rd_q.size());
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		seed = 32'h79f7_ec61;
		errors = 0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		for (int r = 0; r < `REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		test_reset();
		test_reg_ops();
		test_imm_ops();
		test_forwarding();
		test_zero_and_bubbles();
		$display("errors: %0d, cycles: %0d", errors, cycles);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* int_pipe.f */
+incdir+verilog
verilog/int_pipe_pkg.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/int_pipe.sv
tb/int_pipe_chk.sv
tb/int_pipe_tb.sv

/* run.sh */
#!/bin/sh
# builds the int_pipe testbench with Verilator, runs it and fails when the log reports a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module int_pipe_tb \
	-f int_pipe.f -o int_pipe_sim \
	&& ./obj_dir/int_pipe_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
exit 0
